// ==== design/enc_cfg_pkg.sv ====
/*
 * Encoder configuration types.
 * Picture geometry as given at start, CTU grid positions
 * and the per-stage slot carried down the CTU pipeline.
 */
`default_nettype none

package enc_cfg_pkg;

  localparam int LCU_SIZE    = 64;

  // pixel counts
  localparam int PIC_W_WIDTH = 12;
  localparam int PIC_H_WIDTH = 12;

  // CTU indices
  localparam int CTU_X_WIDTH = 6;
  localparam int CTU_Y_WIDTH = 6;

  // ------------------------------
  // picture config, latched on start
  typedef struct packed {
    logic [PIC_W_WIDTH-1:0] all_x;
    logic [PIC_H_WIDTH-1:0] all_y;
    // 1 for P frame
    logic                   is_p;
  } pic_cfg_t;

  typedef struct packed {
    logic [CTU_X_WIDTH-1:0] x;
    logic [CTU_Y_WIDTH-1:0] y;
  } ctu_pos_t;

  // one CTU held by a pipeline stage
  typedef struct packed {
    logic     valid;
    ctu_pos_t pos;
  } stage_slot_t;

endpackage

`default_nettype wire

// ==== design/extif_pkg.sv ====
/*
 * External memory port definitions.
 * Load command fields and the mode codes of the
 * four per-CTU pixel loads.
 */
`default_nettype none

package extif_pkg;

  localparam int EXT_X_WIDTH   = 12;
  localparam int EXT_Y_WIDTH   = 12;
  localparam int EXT_LEN_WIDTH = 8;

  // ------------------------------
  // load modes
  localparam logic [4:0] MODE_CUR_LUMA   = 5'b01000;
  localparam logic [4:0] MODE_REF_LUMA   = 5'b01001;
  localparam logic [4:0] MODE_CUR_CHROMA = 5'b01010;
  localparam logic [4:0] MODE_REF_CHROMA = 5'b01011;

  // window origin and size in pixels
  typedef struct packed {
    logic [4:0]               mode;
    logic [EXT_X_WIDTH-1:0]   x;
    logic [EXT_Y_WIDTH-1:0]   y;
    logic [EXT_LEN_WIDTH-1:0] width;
    logic [EXT_LEN_WIDTH-1:0] height;
  } ext_cmd_t;

endpackage

`default_nettype wire

// ==== design/ctu_pos_counter.sv ====
/*
 * CTU position counter.
 * Derives the CTU grid from the picture size on load and
 * hands out CTU positions in raster order.
 */
`timescale 1ns/1ps
`default_nettype none

module ctu_pos_counter import enc_cfg_pkg::*; (
  input  logic     clk,
  input  logic     rst_n_i,
  input  logic     load_i,
  input  pic_cfg_t cfg_i,
  input  logic     advance_i,
  output ctu_pos_t next_pos_o,
  output logic     remain_o
);

  localparam int LCU_LOG2 = $clog2(LCU_SIZE);

  logic [PIC_W_WIDTH:0]          x_ceil;
  logic [PIC_H_WIDTH:0]          y_ceil;
  logic [PIC_W_WIDTH-LCU_LOG2:0] last_col;
  logic [PIC_H_WIDTH-LCU_LOG2:0] last_row;
  logic [CTU_X_WIDTH-1:0]        last_x_r;
  logic [CTU_Y_WIDTH-1:0]        last_y_r;
  ctu_pos_t                      pos_r;
  logic                          remain_r;

  // round up to whole CTUs
  assign x_ceil   = {1'b0, cfg_i.all_x} + (PIC_W_WIDTH+1)'(LCU_SIZE - 1);
  assign y_ceil   = {1'b0, cfg_i.all_y} + (PIC_H_WIDTH+1)'(LCU_SIZE - 1);
  assign last_col = x_ceil[PIC_W_WIDTH:LCU_LOG2] - 1'b1;
  assign last_row = y_ceil[PIC_H_WIDTH:LCU_LOG2] - 1'b1;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      last_x_r <= '0;
      last_y_r <= '0;
      pos_r    <= '0;
      remain_r <= 1'b0;
    end else if (load_i) begin
      last_x_r <= last_col[CTU_X_WIDTH-1:0];
      last_y_r <= last_row[CTU_Y_WIDTH-1:0];
      pos_r    <= '0;
      remain_r <= 1'b1;
    end else if (advance_i && remain_r) begin
      if (pos_r.x == last_x_r) begin
        pos_r.x <= '0;
        // wrapped past the bottom right CTU
        if (pos_r.y == last_y_r) begin
          remain_r <= 1'b0;
        end else begin
          pos_r.y <= pos_r.y + 1'b1;
        end
      end else begin
        pos_r.x <= pos_r.x + 1'b1;
      end
    end
  end

  assign next_pos_o = pos_r;
  assign remain_o   = remain_r;

endmodule

`default_nettype wire

// ==== design/stage_pos_pipe.sv ====
/*
 * Stage position pipe.
 * One CTU slot per pipeline stage. Slots move up one stage
 * per round, stage 0 is refilled from the position counter,
 * and launch raises the start of every occupied stage.
 */
`timescale 1ns/1ps
`default_nettype none

module stage_pos_pipe import enc_cfg_pkg::*; #(
  parameter int NUM_STAGES = 4
) (
  input  logic                         clk,
  input  logic                         rst_n_i,
  input  logic                         shift_i,
  input  logic                         launch_i,
  input  ctu_pos_t                     next_pos_i,
  input  logic                         remain_i,
  output logic                         advance_o,
  output stage_slot_t [NUM_STAGES-1:0] slots_o,
  output logic [NUM_STAGES-1:0]        valid_o,
  output logic [NUM_STAGES-1:0]        stage_start_o
);

  logic [NUM_STAGES-1:0]     valid_r;
  ctu_pos_t [NUM_STAGES-1:0] pos_r;

  // ------------------------------
  // slot occupancy
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_r <= '0;
    end else if (shift_i) begin
      valid_r <= {valid_r[NUM_STAGES-2:0], remain_i};
    end
  end

  // positions follow the valid bits
  always_ff @(posedge clk) begin
    if (shift_i) begin
      pos_r <= {pos_r[NUM_STAGES-2:0], next_pos_i};
    end
  end

  // counter steps only when stage 0 takes a CTU
  assign advance_o = shift_i & remain_i;

  // ------------------------------
  // outputs
  for (genvar k = 0; k < NUM_STAGES; k++) begin : g_slot
    assign slots_o[k] = {valid_r[k], pos_r[k]};
  end

  assign valid_o       = valid_r;
  assign stage_start_o = valid_r & {NUM_STAGES{launch_i}};

endmodule

`default_nettype wire

// ==== design/fetch_cmd_gen.sv ====
/*
 * Fetch command sequencer.
 * For one CTU, issues the current luma and chroma loads and,
 * in P frames, the reference windows around the CTU, one at
 * a time on the external memory port.
 */
`timescale 1ns/1ps
`default_nettype none

module fetch_cmd_gen import enc_cfg_pkg::*, extif_pkg::*; #(
  parameter int SEARCH_RANGE = 32
) (
  input  logic     clk,
  input  logic     rst_n_i,
  input  logic     start_i,
  input  ctu_pos_t pos_i,
  input  logic     is_p_i,
  input  logic     extif_done_i,
  output logic     extif_start_o,
  output ext_cmd_t extif_cmd_o,
  output logic     done_o
);

  localparam int LCU_LOG2 = $clog2(LCU_SIZE);

  localparam logic [EXT_X_WIDTH-1:0]   SR_X      = EXT_X_WIDTH'(SEARCH_RANGE);
  localparam logic [EXT_Y_WIDTH-1:0]   SR_Y      = EXT_Y_WIDTH'(SEARCH_RANGE);
  localparam logic [EXT_Y_WIDTH-1:0]   SR_Y_HALF = EXT_Y_WIDTH'(SEARCH_RANGE / 2);
  localparam logic [EXT_LEN_WIDTH-1:0] CUR_LEN   = EXT_LEN_WIDTH'(LCU_SIZE);
  localparam logic [EXT_LEN_WIDTH-1:0] CUR_CH_H  = EXT_LEN_WIDTH'(LCU_SIZE / 2);
  localparam logic [EXT_LEN_WIDTH-1:0] REF_LEN   = EXT_LEN_WIDTH'(LCU_SIZE + 2 * SEARCH_RANGE);
  localparam logic [EXT_LEN_WIDTH-1:0] REF_CH_H  = EXT_LEN_WIDTH'(LCU_SIZE / 2 + SEARCH_RANGE);

  logic [1:0]             step_r;
  logic [1:0]             issue_step;
  logic [1:0]             last_step;
  logic                   pend_r;
  logic                   start_r;
  logic                   done_r;
  logic                   issue;
  logic                   last_done;
  logic [EXT_X_WIDTH-1:0] x_cur;
  logic [EXT_X_WIDTH-1:0] x_ref;
  logic [EXT_Y_WIDTH-1:0] y_luma;
  logic [EXT_Y_WIDTH-1:0] y_chroma;
  logic [EXT_Y_WIDTH-1:0] y_ref_luma;
  logic [EXT_Y_WIDTH-1:0] y_ref_chroma;
  ext_cmd_t               cmd_next;
  ext_cmd_t               cmd_r;

  // ------------------------------
  // step control
  assign last_step  = is_p_i ? 2'd3 : 2'd1;
  assign last_done  = pend_r & extif_done_i & (step_r == last_step);
  assign issue      = start_i | (pend_r & extif_done_i & (step_r != last_step));
  assign issue_step = start_i ? 2'd0 : step_r + 2'd1;

  // window origins, reference ones clamped at the picture edge
  assign x_cur        = EXT_X_WIDTH'(pos_i.x) << LCU_LOG2;
  assign y_luma       = EXT_Y_WIDTH'(pos_i.y) << LCU_LOG2;
  assign y_chroma     = EXT_Y_WIDTH'(pos_i.y) << (LCU_LOG2 - 1);
  assign x_ref        = (x_cur > SR_X) ? x_cur - SR_X : '0;
  assign y_ref_luma   = (y_luma > SR_Y) ? y_luma - SR_Y : '0;
  assign y_ref_chroma = (y_chroma > SR_Y_HALF) ? y_chroma - SR_Y_HALF : '0;

  always_comb begin
    cmd_next.mode   = MODE_CUR_LUMA;
    cmd_next.x      = x_cur;
    cmd_next.y      = y_luma;
    cmd_next.width  = CUR_LEN;
    cmd_next.height = CUR_LEN;
    case (issue_step)
      2'd1: begin
        cmd_next.mode   = MODE_CUR_CHROMA;
        cmd_next.y      = y_chroma;
        cmd_next.height = CUR_CH_H;
      end
      2'd2: begin
        cmd_next.mode   = MODE_REF_LUMA;
        cmd_next.x      = x_ref;
        cmd_next.y      = y_ref_luma;
        cmd_next.width  = REF_LEN;
        cmd_next.height = REF_LEN;
      end
      2'd3: begin
        cmd_next.mode   = MODE_REF_CHROMA;
        cmd_next.x      = x_ref;
        cmd_next.y      = y_ref_chroma;
        cmd_next.width  = REF_LEN;
        cmd_next.height = REF_CH_H;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      step_r  <= '0;
      pend_r  <= 1'b0;
      start_r <= 1'b0;
      done_r  <= 1'b0;
    end else begin
      start_r <= issue;
      done_r  <= last_done;
      if (issue) begin
        step_r <= issue_step;
        pend_r <= 1'b1;
      end else if (extif_done_i) begin
        pend_r <= 1'b0;
      end
    end
  end

  // held until the memory side answers
  always_ff @(posedge clk) begin
    if (issue) begin
      cmd_r <= cmd_next;
    end
  end

  assign extif_start_o = start_r;
  assign extif_cmd_o   = cmd_r;
  assign done_o        = done_r;

endmodule

`default_nettype wire

// ==== design/enc_ctrl_fsm.sv ====
/*
 * Pipeline round controller.
 * Shifts the stage slots, launches the occupied stages and
 * waits until each of them has reported done. Ends the run
 * once a shift leaves every stage empty.
 */
`timescale 1ns/1ps
`default_nettype none

module enc_ctrl_fsm #(
  parameter int NUM_STAGES = 4
) (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  sys_start_i,
  input  logic [NUM_STAGES-1:0] valid_i,
  input  logic [NUM_STAGES-1:0] stage_done_i,
  output logic                  load_o,
  output logic                  shift_o,
  output logic                  launch_o,
  output logic                  sys_done_o
);

  typedef enum logic [2:0] {
    IDLE,
    SHIFT,
    LAUNCH,
    WAIT,
    FINISH
  } state_t;

  state_t                state_r;
  state_t                state_nxt;
  logic [NUM_STAGES-1:0] done_r;
  logic [NUM_STAGES-1:0] done_all;
  logic                  drained_r;
  logic                  round_done;
  logic                  last_round;

  // ------------------------------
  // sticky dones of this round
  assign done_all   = done_r | (stage_done_i & valid_i);
  assign round_done = &(done_all | ~valid_i);

  // counter is empty and only the top stage still holds a CTU
  assign last_round = drained_r && (valid_i[NUM_STAGES-2:0] == '0);

  always_comb begin
    state_nxt = state_r;
    case (state_r)
      IDLE:    if (sys_start_i) state_nxt = SHIFT;
      SHIFT:   state_nxt = last_round ? FINISH : LAUNCH;
      LAUNCH:  state_nxt = WAIT;
      WAIT:    if (round_done) state_nxt = SHIFT;
      FINISH:  state_nxt = IDLE;
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_r   <= IDLE;
      done_r    <= '0;
      drained_r <= 1'b0;
    end else begin
      state_r <= state_nxt;
      if (state_r == LAUNCH) begin
        done_r <= '0;
      end else if (state_r == WAIT) begin
        done_r <= done_all;
      end
      // stage 0 came up empty after a shift
      if (load_o) begin
        drained_r <= 1'b0;
      end else if (state_r == LAUNCH && !valid_i[0]) begin
        drained_r <= 1'b1;
      end
    end
  end

  assign load_o     = (state_r == IDLE) & sys_start_i;
  assign shift_o    = (state_r == SHIFT);
  assign launch_o   = (state_r == LAUNCH);
  assign sys_done_o = (state_r == FINISH);

endmodule

`default_nettype wire

// ==== design/h265_ctu_sched_top.sv ====
/*
 * CTU pipeline scheduler top.
 * Runs the CTUs of a picture through the fetch stage and the
 * external encoder core stages, one CTU per stage per round.
 */
`timescale 1ns/1ps
`default_nettype none

module h265_ctu_sched_top import enc_cfg_pkg::*, extif_pkg::*; #(
  parameter int NUM_STAGES   = 4,
  parameter int SEARCH_RANGE = 32
) (
  input  logic                      clk,
  input  logic                      rst_n_i,
  // system
  input  logic                      sys_start_i,
  input  pic_cfg_t                  sys_cfg_i,
  output logic                      sys_done_o,
  // external memory
  output logic                      extif_start_o,
  output ext_cmd_t                  extif_cmd_o,
  input  logic                      extif_done_i,
  // core stages 1 and up
  output logic [NUM_STAGES-2:0]     core_start_o,
  output ctu_pos_t [NUM_STAGES-2:0] core_pos_o,
  input  logic [NUM_STAGES-2:0]     core_done_i
);

  logic                         ctr_load;
  logic                         ctr_advance;
  logic                         ctr_remain;
  ctu_pos_t                     next_pos;
  logic                         shift;
  logic                         launch;
  stage_slot_t [NUM_STAGES-1:0] slots;
  logic [NUM_STAGES-1:0]        stage_valid;
  logic [NUM_STAGES-1:0]        stage_start;
  logic [NUM_STAGES-1:0]        stage_done;
  logic                         fetch_done;

  // ------------------------------
  // control
  enc_ctrl_fsm #(
    .NUM_STAGES   ( NUM_STAGES   )
  ) u_enc_ctrl_fsm (
    .clk          ( clk          ),
    .rst_n_i      ( rst_n_i      ),
    .sys_start_i  ( sys_start_i  ),
    .valid_i      ( stage_valid  ),
    .stage_done_i ( stage_done   ),
    .load_o       ( ctr_load     ),
    .shift_o      ( shift        ),
    .launch_o     ( launch       ),
    .sys_done_o   ( sys_done_o   )
  );

  ctu_pos_counter u_ctu_pos_counter (
    .clk          ( clk          ),
    .rst_n_i      ( rst_n_i      ),
    .load_i       ( ctr_load     ),
    .cfg_i        ( sys_cfg_i    ),
    .advance_i    ( ctr_advance  ),
    .next_pos_o   ( next_pos     ),
    .remain_o     ( ctr_remain   )
  );

  stage_pos_pipe #(
    .NUM_STAGES    ( NUM_STAGES   )
  ) u_stage_pos_pipe (
    .clk           ( clk          ),
    .rst_n_i       ( rst_n_i      ),
    .shift_i       ( shift        ),
    .launch_i      ( launch       ),
    .next_pos_i    ( next_pos     ),
    .remain_i      ( ctr_remain   ),
    .advance_o     ( ctr_advance  ),
    .slots_o       ( slots        ),
    .valid_o       ( stage_valid  ),
    .stage_start_o ( stage_start  )
  );

  // ------------------------------
  // fetch, stage 0
  fetch_cmd_gen #(
    .SEARCH_RANGE  ( SEARCH_RANGE   )
  ) u_fetch_cmd_gen (
    .clk           ( clk            ),
    .rst_n_i       ( rst_n_i        ),
    .start_i       ( stage_start[0] ),
    .pos_i         ( slots[0].pos   ),
    .is_p_i        ( sys_cfg_i.is_p ),
    .extif_done_i  ( extif_done_i   ),
    .extif_start_o ( extif_start_o  ),
    .extif_cmd_o   ( extif_cmd_o    ),
    .done_o        ( fetch_done     )
  );

  // core stages
  assign stage_done   = {core_done_i, fetch_done};
  assign core_start_o = stage_start[NUM_STAGES-1:1];

  for (genvar k = 1; k < NUM_STAGES; k++) begin : g_core_pos
    assign core_pos_o[k-1] = slots[k].pos;
  end

endmodule

`default_nettype wire

// ==== tests/ctu_sched_props.sv ====
/*
 * Scheduler properties.
 * Bound to the scheduler top; checks the external load
 * handshake, single core starts per round and the done pulse.
 */
`timescale 1ns/1ps
`default_nettype none

module ctu_sched_props #(
  parameter int NUM_STAGES = 4
) (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  extif_start_i,
  input  logic                  extif_done_i,
  input  logic [NUM_STAGES-2:0] core_start_i,
  input  logic                  shift_i,
  input  logic                  sys_done_i
);

  int unsigned           fail_cnt = 0;
  logic                  cmd_open_r;
  logic [NUM_STAGES-2:0] started_r;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cmd_open_r <= 1'b0;
      started_r  <= '0;
    end else begin
      if (extif_start_i) begin
        cmd_open_r <= 1'b1;
      end else if (extif_done_i) begin
        cmd_open_r <= 1'b0;
      end
      // a new round begins at shift
      started_r <= shift_i ? '0 : (started_r | core_start_i);
    end
  end

  a_one_load: assert property (@(posedge clk) disable iff (!rst_n_i)
    extif_start_i |-> !cmd_open_r)
    else begin
      fail_cnt++;
      $error("external load started while another one is outstanding");
    end

  a_start_once: assert property (@(posedge clk) disable iff (!rst_n_i)
    (core_start_i & started_r) == '0)
    else begin
      fail_cnt++;
      $error("core stage started twice in one round");
    end

  a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
    sys_done_i |=> !sys_done_i)
    else begin
      fail_cnt++;
      $error("sys_done_o held longer than one cycle");
    end

endmodule

bind h265_ctu_sched_top ctu_sched_props #(
  .NUM_STAGES    ( NUM_STAGES    )
) u_props (
  .clk           ( clk           ),
  .rst_n_i       ( rst_n_i       ),
  .extif_start_i ( extif_start_o ),
  .extif_done_i  ( extif_done_i  ),
  .core_start_i  ( core_start_o  ),
  .shift_i       ( shift         ),
  .sys_done_i    ( sys_done_o    )
);

`default_nettype wire

// ==== tests/ctu_sched_tb.sv ====
/*
 * CTU scheduler testbench.
 * Runs pictures of fixed and random size through the DUT with
 * random-latency core and memory responders, and checks loads,
 * stage positions and round counts against a raster-order model.
 */
`timescale 1ns/1ps
`default_nettype none

module ctu_sched_tb import enc_cfg_pkg::*, extif_pkg::*;;

  localparam int NUM_STAGES   = 4;
  localparam int SEARCH_RANGE = 32;
  localparam int NUM_CORE     = NUM_STAGES - 1;
  localparam int PERIOD       = 20;
  localparam int MAX_LAT      = 12;
  localparam int NUM_RUNS     = 6;
  localparam logic [31:0] SEED = 32'd88158;

  logic                    clk;
  logic                    rst_n_i;
  logic                    sys_start_i;
  pic_cfg_t                sys_cfg_i;
  logic                    sys_done_o;
  logic                    extif_start_o;
  ext_cmd_t                extif_cmd_o;
  logic                    extif_done_i;
  logic [NUM_CORE-1:0]     core_start_o;
  ctu_pos_t [NUM_CORE-1:0] core_pos_o;
  logic [NUM_CORE-1:0]     core_done_i;

  int          errors;
  int          checks;
  int          tests_run;
  int          tests_failed;
  string       test_name;
  logic [31:0] size_seed;
  logic [31:0] lat_seed;
  int          stage_cnt [NUM_CORE];
  int          core_wait [NUM_CORE];
  int          mem_wait;
  ext_cmd_t    exp_cmds [$];
  ext_cmd_t    last_cmd;
  int          grid_cols;
  int          grid_ctus;
  int          edge_cnt;
  int          last_done_edge;
  int          sys_done_edge;
  int          done_cnt;
  longint      watchdog_ns;
  string       run_name [NUM_RUNS];
  int          run_w [NUM_RUNS];
  int          run_h [NUM_RUNS];
  logic        run_p [NUM_RUNS];
  logic        run_poke [NUM_RUNS];

  h265_ctu_sched_top #(
    .NUM_STAGES    ( NUM_STAGES    ),
    .SEARCH_RANGE  ( SEARCH_RANGE  )
  ) DUT (
    .clk           ( clk           ),
    .rst_n_i       ( rst_n_i       ),
    .sys_start_i   ( sys_start_i   ),
    .sys_cfg_i     ( sys_cfg_i     ),
    .sys_done_o    ( sys_done_o    ),
    .extif_start_o ( extif_start_o ),
    .extif_cmd_o   ( extif_cmd_o   ),
    .extif_done_i  ( extif_done_i  ),
    .core_start_o  ( core_start_o  ),
    .core_pos_o    ( core_pos_o    ),
    .core_done_i   ( core_done_i   )
  );

  always #(PERIOD / 2) clk = ~clk;

  // ------------------------------
  // helpers
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] v;
    v = s ^ (s << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  function automatic int pick_below(input int span);
    size_seed = xorshift32(size_seed);
    return int'(size_seed % span);
  endfunction

  function automatic int ctus_along(input int pixels);
    return (pixels + LCU_SIZE - 1) / LCU_SIZE;
  endfunction

  function automatic int clamp_low(input int v);
    return (v < 0) ? 0 : v;
  endfunction

  function automatic ext_cmd_t make_cmd(input logic [4:0] mode, input int x, input int y,
                                        input int w, input int h);
    ext_cmd_t c;
    c.mode   = mode;
    c.x      = EXT_X_WIDTH'(x);
    c.y      = EXT_Y_WIDTH'(y);
    c.width  = EXT_LEN_WIDTH'(w);
    c.height = EXT_LEN_WIDTH'(h);
    return c;
  endfunction

  task automatic queue_ctu_loads(input int cx, input int cy, input logic is_p);
    int rx;
    int rw;
    rx = clamp_low(cx * LCU_SIZE - SEARCH_RANGE);
    rw = LCU_SIZE + 2 * SEARCH_RANGE;
    exp_cmds.push_back(make_cmd(MODE_CUR_LUMA, cx * LCU_SIZE, cy * LCU_SIZE, LCU_SIZE, LCU_SIZE));
    exp_cmds.push_back(make_cmd(MODE_CUR_CHROMA, cx * LCU_SIZE, cy * LCU_SIZE / 2,
                                LCU_SIZE, LCU_SIZE / 2));
    if (is_p) begin
      exp_cmds.push_back(make_cmd(MODE_REF_LUMA, rx,
                                  clamp_low(cy * LCU_SIZE - SEARCH_RANGE), rw, rw));
      exp_cmds.push_back(make_cmd(MODE_REF_CHROMA, rx,
                                  clamp_low(cy * LCU_SIZE / 2 - SEARCH_RANGE / 2), rw, rw / 2));
    end
  endtask

  task automatic check_value(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("error %s: %s expected %0h actual %0h", test_name, what, expected, actual);
    end
  endtask

  task automatic note_failure(input string what);
    errors++;
    $display("%s: %s", test_name, what);
  endtask

  // ------------------------------
  // core and memory responders
  always @(negedge clk) begin : responders
    int       round_now;
    int       idx;
    ctu_pos_t exp_pos;
    round_now = -1;
    edge_cnt++;
    for (int k = 0; k < NUM_CORE; k++) begin
      core_done_i[k] = 1'b0;
      if (core_wait[k] > 0) begin
        core_wait[k]--;
        if (core_wait[k] == 0) begin
          core_done_i[k] = 1'b1;
          last_done_edge = edge_cnt;
        end
      end
      if (core_start_o[k]) begin
        idx = stage_cnt[k];
        // stage k+1 works on CTU r-(k+1) in round r
        if (round_now < 0) round_now = idx + k + 1;
        check_value($sformatf("round of stage %0d", k + 1), round_now, idx + k + 1);
        if (idx >= grid_ctus) begin
          note_failure($sformatf("stage %0d started with no CTU left", k + 1));
        end else begin
          exp_pos.x = CTU_X_WIDTH'(idx % grid_cols);
          exp_pos.y = CTU_Y_WIDTH'(idx / grid_cols);
          check_value($sformatf("stage %0d position", k + 1), exp_pos, core_pos_o[k]);
        end
        stage_cnt[k]++;
        lat_seed = xorshift32(lat_seed);
        core_wait[k] = 1 + int'(lat_seed % MAX_LAT);
      end
    end
    extif_done_i = 1'b0;
    if (mem_wait > 0) begin
      mem_wait--;
      if (mem_wait == 0) begin
        check_value("load held until done", last_cmd, extif_cmd_o);
        extif_done_i = 1'b1;
      end
    end
    if (extif_start_o) begin
      last_cmd = extif_cmd_o;
      if (exp_cmds.size() == 0) begin
        note_failure("external load issued after the last load of the picture");
      end else begin
        check_value("external load", exp_cmds.pop_front(), extif_cmd_o);
      end
      lat_seed = xorshift32(lat_seed);
      mem_wait = 1 + int'(lat_seed % MAX_LAT);
    end
    if (sys_done_o) begin
      done_cnt++;
      sys_done_edge = edge_cnt;
    end
  end

  task automatic run_picture(input string name, input int w, input int h, input logic is_p,
                             input logic poke_start);
    int err_before;
    int done_before;
    test_name  = name;
    err_before = errors;
    grid_cols  = ctus_along(w);
    grid_ctus  = grid_cols * ctus_along(h);
    exp_cmds.delete();
    for (int k = 0; k < NUM_CORE; k++) stage_cnt[k] = 0;
    for (int i = 0; i < grid_ctus; i++) queue_ctu_loads(i % grid_cols, i / grid_cols, is_p);
    done_before = done_cnt;
    sys_cfg_i.all_x = PIC_W_WIDTH'(w);
    sys_cfg_i.all_y = PIC_H_WIDTH'(h);
    sys_cfg_i.is_p  = is_p;
    sys_start_i     = 1'b1;
    @(negedge clk);
    sys_start_i = 1'b0;
    if (poke_start) begin
      // stray start once the core stages are busy
      while (stage_cnt[0] == 0 && done_cnt == done_before) @(negedge clk);
      sys_start_i = 1'b1;
      @(negedge clk);
      sys_start_i = 1'b0;
    end
    while (done_cnt == done_before) @(negedge clk);
    repeat (4) @(negedge clk);
    check_value("sys_done pulses", 1, done_cnt - done_before);
    // last round closes, one shift cycle, then sys_done
    check_value("sys_done delay after last done", 2, sys_done_edge - last_done_edge);
    for (int k = 0; k < NUM_CORE; k++) begin
      check_value($sformatf("stage %0d starts", k + 1), grid_ctus, stage_cnt[k]);
    end
    check_value("loads left", 0, exp_cmds.size());
    tests_run++;
    if (errors != err_before) tests_failed++;
    $display("test %s: %0dx%0d %s frame, %0d CTUs, %s", name, w, h, is_p ? "P" : "I",
             grid_ctus, (errors == err_before) ? "ok" : "failed");
  endtask

  // ------------------------------
  // test sequence
  initial begin : test_seq
    longint total_rounds;
    clk = 1'b0;
    rst_n_i = 1'b0;
    sys_start_i = 1'b0;
    sys_cfg_i = '0;
    extif_done_i = 1'b0;
    core_done_i = '0;
    errors = 0;
    checks = 0;
    tests_run = 0;
    tests_failed = 0;
    test_name = "setup";
    mem_wait = 0;
    for (int k = 0; k < NUM_CORE; k++) core_wait[k] = 0;
    last_cmd = '0;
    grid_cols = 1;
    grid_ctus = 0;
    edge_cnt = 0;
    last_done_edge = 0;
    sys_done_edge = 0;
    done_cnt = 0;
    watchdog_ns = 0;
    size_seed = SEED;
    lat_seed = ~SEED;
    run_name = '{"i_frame_loads", "p_frame_clamp", "round_up_size",
                 "stage_positions", "start_during_run", "restart_at_origin"};
    run_poke = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
    for (int i = 0; i < NUM_RUNS; i++) begin
      run_w[i] = 65 + pick_below(256);
      run_h[i] = 65 + pick_below(192);
      run_p[i] = pick_below(2) == 1;
    end
    run_w[0] = 192;
    run_h[0] = 128;
    run_p[0] = 1'b0;
    run_p[1] = 1'b1;
    run_w[2] = 200;
    run_h[2] = 72;
    run_p[4] = 1'b1;
    total_rounds = 0;
    for (int i = 0; i < NUM_RUNS; i++) begin
      total_rounds += ctus_along(run_w[i]) * ctus_along(run_h[i]) + NUM_STAGES - 1;
    end
    watchdog_ns = (total_rounds * 4 * (MAX_LAT + 2) + 200) * PERIOD;
    repeat (5) @(negedge clk);
    rst_n_i = 1'b1;
    repeat (2) @(negedge clk);
    for (int i = 0; i < NUM_RUNS; i++) begin
      run_picture(run_name[i], run_w[i], run_h[i], run_p[i], run_poke[i]);
    end
    test_name = "properties";
    check_value("assertion failures", 0, DUT.u_props.fail_cnt);
    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin : watchdog
    wait (watchdog_ns > 0);
    #(watchdog_ns);
    $display("watchdog expired after %0d ns, the DUT never finished its pictures",
             watchdog_ns);
    $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
design/enc_cfg_pkg.sv
design/extif_pkg.sv
design/ctu_pos_counter.sv
design/stage_pos_pipe.sv
design/fetch_cmd_gen.sv
design/enc_ctrl_fsm.sv
design/h265_ctu_sched_top.sv
tests/ctu_sched_props.sv
tests/ctu_sched_tb.sv
